/* verilog/mmul_params.svh */
`ifndef MMUL_PARAMS_SVH
`define MMUL_PARAMS_SVH

// matrix order, both operands square
`define MMUL_DIM 6

// signed operand width
`define MMUL_ELEM_W 16

// 32-bit products plus headroom for six of them
`define MMUL_ACC_W 40

// peer multiply-accumulate lanes
`define MMUL_LANES 2

// A then B, column-major
`define MMUL_OPND_DEPTH 72

// one word per result entry
`define MMUL_RES_DEPTH 36

`endif

/* verilog/mmul_ctrl_pkg.sv */
`include "mmul_params.svh"

package mmul_ctrl_pkg;

	// operand store address, A at 0..35 and B at 36..71
	typedef logic [$clog2(`MMUL_OPND_DEPTH)-1:0] opnd_addr_t;

	// result entry j*6+i
	typedef logic [$clog2(`MMUL_RES_DEPTH)-1:0] res_addr_t;

	typedef logic [$clog2(`MMUL_LANES)-1:0] lane_id_t;

	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_finish
	} seq_state_t;

endpackage

/* verilog/mmul_data_pkg.sv */
`include "mmul_params.svh"

package mmul_data_pkg;

	typedef logic signed [`MMUL_ELEM_W-1:0] elem_t;

	typedef logic signed [`MMUL_ACC_W-1:0] acc_t;

	// one result store write, address in the upper bits
	typedef struct packed {
		mmul_ctrl_pkg::res_addr_t addr;
		acc_t                     data;
	} res_wr_t;

endpackage

/* verilog/matrix_store.sv */
`timescale 1ns/10ps

module matrix_store #(
	parameter type word_t = logic,
	parameter int  DEPTH  = 2
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  word_t                    wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output word_t                    rdata
);

	word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr]; // registered read, one cycle latency
	end

endmodule

/* verilog/rr_arbiter.sv */
`timescale 1ns/10ps

module rr_arbiter #(
	parameter type req_t = logic,
	parameter int  N     = 2
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [N-1:0]       req,
	input  req_t [N-1:0]       req_data,
	output logic [N-1:0]       gnt,
	output logic               gnt_valid,
	output req_t               gnt_data
);

	localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

	logic [PTR_W-1:0] last; // last requester served
	logic [PTR_W-1:0] sel;
	logic             found;

	// search starts one past the last grant
	always_comb begin
		sel   = '0;
		found = 1'b0;
		for (int off = 1; off <= N; off++) begin
			if (!found && req[(int'(last) + off) % N]) begin
				found = 1'b1;
				sel   = PTR_W'((int'(last) + off) % N);
			end
		end
	end

	always_comb begin
		gnt      = '0;
		gnt[sel] = found;
	end

	assign gnt_valid = found;
	assign gnt_data  = req_data[sel]; // payload of the winner

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last <= PTR_W'(N - 1); // requester 0 first after reset
		end else if (found) begin
			last <= sel;
		end
	end

endmodule

/* verilog/dot_product_lane.sv */
`timescale 1ns/10ps

`include "mmul_params.svh"

module dot_product_lane (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       assign_en,
	input  mmul_ctrl_pkg::res_addr_t   assign_entry,
	output logic                       idle,
	output logic                       opnd_req,
	output mmul_ctrl_pkg::opnd_addr_t  opnd_addr,
	input  logic                       opnd_gnt,
	input  mmul_data_pkg::elem_t       opnd_data,
	output logic                       res_req,
	output mmul_data_pkg::res_wr_t     res_wr,
	input  logic                       res_gnt
);

	localparam int IDX_W = $clog2(`MMUL_DIM);

	logic active;
	logic rd_pend;   // operand read outstanding
	logic sel_b;     // current fetch is the B element
	logic take;      // read data belongs to this lane
	logic take_b;
	logic take_last;
	logic wr_pend;
	logic last_step;

	logic [IDX_W-1:0] k;
	logic [IDX_W-1:0] idx_i;
	logic [IDX_W-1:0] idx_j;

	mmul_ctrl_pkg::res_addr_t entry_q;
	mmul_data_pkg::elem_t     a_q;
	mmul_data_pkg::acc_t      acc;

	logic signed [2*`MMUL_ELEM_W-1:0] prod;

	assign idle      = !active;
	assign last_step = (k == IDX_W'(`MMUL_DIM - 1));

	// A(i,k) at k*6+i, B(k,j) at 36+j*6+k
	assign opnd_addr = sel_b ?
		mmul_ctrl_pkg::opnd_addr_t'(`MMUL_DIM * `MMUL_DIM + idx_j * `MMUL_DIM + k) :
		mmul_ctrl_pkg::opnd_addr_t'(k * `MMUL_DIM + idx_i);
	assign opnd_req  = rd_pend;

	assign prod    = a_q * opnd_data; // exact 32-bit product
	assign res_req = wr_pend;
	assign res_wr  = '{addr: entry_q, data: acc};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active    <= 1'b0;
			rd_pend   <= 1'b0;
			sel_b     <= 1'b0;
			k         <= '0;
			take      <= 1'b0;
			take_b    <= 1'b0;
			take_last <= 1'b0;
			wr_pend   <= 1'b0;
		end else begin
			take      <= opnd_gnt;
			take_b    <= sel_b;
			take_last <= sel_b && last_step;
			if (assign_en) begin
				active  <= 1'b1;
				rd_pend <= 1'b1;
				sel_b   <= 1'b0;
				k       <= '0;
			end else if (opnd_gnt) begin
				sel_b <= !sel_b; // A then B, alternating
				if (sel_b) begin
					if (last_step) begin
						rd_pend <= 1'b0;
					end else begin
						k <= k + 1'b1;
					end
				end
			end
			if (take && take_b && take_last) begin
				wr_pend <= 1'b1; // final sum lands this edge
			end else if (res_gnt) begin
				wr_pend <= 1'b0;
				active  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (assign_en) begin
			entry_q <= assign_entry;
			idx_i   <= IDX_W'(assign_entry % `MMUL_DIM);
			idx_j   <= IDX_W'(assign_entry / `MMUL_DIM);
			acc     <= '0;
		end else if (take) begin
			if (take_b) begin
				acc <= acc + prod;
			end else begin
				a_q <= opnd_data;
			end
		end
	end

endmodule

/* verilog/mmul_sequencer.sv */
`timescale 1ns/10ps

`include "mmul_params.svh"

module mmul_sequencer (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      start,
	input  logic [`MMUL_LANES-1:0]    lane_idle,
	output logic [`MMUL_LANES-1:0]    assign_en,
	output mmul_ctrl_pkg::res_addr_t  assign_entry,
	input  logic                      res_written,
	output logic                      busy,
	output logic                      done_tick
);

	mmul_ctrl_pkg::seq_state_t state;
	mmul_ctrl_pkg::res_addr_t  deal_cnt; // entries handed out
	mmul_ctrl_pkg::res_addr_t  wr_cnt;   // results stored
	mmul_ctrl_pkg::lane_id_t   pick;
	logic                      pick_ok;
	logic                      can_deal;

	// lowest numbered idle lane
	always_comb begin
		pick    = '0;
		pick_ok = 1'b0;
		for (int n = `MMUL_LANES - 1; n >= 0; n--) begin
			if (lane_idle[n]) begin
				pick    = mmul_ctrl_pkg::lane_id_t'(n);
				pick_ok = 1'b1;
			end
		end
	end

	assign can_deal = (state == mmul_ctrl_pkg::st_busy) && pick_ok &&
		(deal_cnt < `MMUL_RES_DEPTH);

	always_comb begin
		assign_en       = '0;
		assign_en[pick] = can_deal;
	end

	assign assign_entry = deal_cnt;
	assign busy         = (state == mmul_ctrl_pkg::st_busy);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= mmul_ctrl_pkg::st_idle;
			deal_cnt  <= '0;
			wr_cnt    <= '0;
			done_tick <= 1'b0;
		end else begin
			case (state)
				mmul_ctrl_pkg::st_idle: begin
					done_tick <= 1'b0;
					if (start) begin
						state    <= mmul_ctrl_pkg::st_busy;
						deal_cnt <= '0;
						wr_cnt   <= '0;
					end
				end
				mmul_ctrl_pkg::st_busy: begin
					if (can_deal) begin
						deal_cnt <= deal_cnt + 1'b1;
					end
					if (res_written) begin
						wr_cnt <= wr_cnt + 1'b1;
						if (wr_cnt == `MMUL_RES_DEPTH - 1) begin
							state     <= mmul_ctrl_pkg::st_finish; // busy drops here
							done_tick <= 1'b1;
						end
					end
				end
				mmul_ctrl_pkg::st_finish: begin
					done_tick <= 1'b0;
					state     <= mmul_ctrl_pkg::st_idle;
				end
				default: state <= mmul_ctrl_pkg::st_idle;
			endcase
		end
	end

endmodule

/* verilog/mmul_top.sv */
`timescale 1ns/10ps

`include "mmul_params.svh"

module mmul_top (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       ld_we,
	input  mmul_ctrl_pkg::opnd_addr_t  ld_addr,
	input  mmul_data_pkg::elem_t       ld_data,
	input  logic                       start,
	output logic                       busy,
	output logic                       done_tick,
	input  mmul_ctrl_pkg::res_addr_t   rd_addr,
	output mmul_data_pkg::acc_t        rd_data
);

	logic [`MMUL_LANES-1:0] lane_idle;
	logic [`MMUL_LANES-1:0] assign_en;
	logic [`MMUL_LANES-1:0] opnd_req;
	logic [`MMUL_LANES-1:0] opnd_gnt;
	logic [`MMUL_LANES-1:0] res_req;
	logic [`MMUL_LANES-1:0] res_gnt;

	mmul_ctrl_pkg::res_addr_t                     assign_entry;
	mmul_ctrl_pkg::opnd_addr_t [`MMUL_LANES-1:0]  opnd_addr;
	mmul_ctrl_pkg::opnd_addr_t                    opnd_rd_addr;
	mmul_data_pkg::elem_t                         opnd_rd_data;
	mmul_data_pkg::res_wr_t [`MMUL_LANES-1:0]     res_wr;
	mmul_data_pkg::res_wr_t                       res_wr_rec;
	logic                                         res_wr_valid;

	matrix_store #(
		.word_t (mmul_data_pkg::elem_t),
		.DEPTH  (`MMUL_OPND_DEPTH)
	) opnd_store_i (
		.clk   (clk),
		.we    (ld_we),
		.waddr (ld_addr),
		.wdata (ld_data),
		.raddr (opnd_rd_addr),
		.rdata (opnd_rd_data) // broadcast to every lane
	);

	matrix_store #(
		.word_t (mmul_data_pkg::acc_t),
		.DEPTH  (`MMUL_RES_DEPTH)
	) res_store_i (
		.clk   (clk),
		.we    (res_wr_valid),
		.waddr (res_wr_rec.addr),
		.wdata (res_wr_rec.data),
		.raddr (rd_addr),
		.rdata (rd_data)
	);

	rr_arbiter #(
		.req_t (mmul_ctrl_pkg::opnd_addr_t),
		.N     (`MMUL_LANES)
	) opnd_arb_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (opnd_req),
		.req_data  (opnd_addr),
		.gnt       (opnd_gnt),
		.gnt_valid (),
		.gnt_data  (opnd_rd_addr)
	);

	rr_arbiter #(
		.req_t (mmul_data_pkg::res_wr_t),
		.N     (`MMUL_LANES)
	) res_arb_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (res_req),
		.req_data  (res_wr),
		.gnt       (res_gnt),
		.gnt_valid (res_wr_valid),
		.gnt_data  (res_wr_rec)
	);

	for (genvar g = 0; g < `MMUL_LANES; g++) begin : g_lane
		dot_product_lane lane_i (
			.clk          (clk),
			.arst_n       (arst_n),
			.assign_en    (assign_en[g]),
			.assign_entry (assign_entry),
			.idle         (lane_idle[g]),
			.opnd_req     (opnd_req[g]),
			.opnd_addr    (opnd_addr[g]),
			.opnd_gnt     (opnd_gnt[g]),
			.opnd_data    (opnd_rd_data),
			.res_req      (res_req[g]),
			.res_wr       (res_wr[g]),
			.res_gnt      (res_gnt[g])
		);
	end

	mmul_sequencer seq_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start),
		.lane_idle    (lane_idle),
		.assign_en    (assign_en),
		.assign_entry (assign_entry),
		.res_written  (res_wr_valid),
		.busy         (busy),
		.done_tick    (done_tick)
	);

endmodule

/* testbench/mmul_props.sv */
`timescale 1ns/10ps

`include "mmul_params.svh"

module mmul_props (
	input logic                                         clk,
	input logic                                         arst_n,
	input logic                                         ld_we,
	input logic                                         busy,
	input logic                                         done_tick,
	input logic [`MMUL_LANES-1:0]                       opnd_req,
	input logic [`MMUL_LANES-1:0]                       opnd_gnt,
	input mmul_ctrl_pkg::opnd_addr_t [`MMUL_LANES-1:0]  opnd_addr,
	input logic [`MMUL_LANES-1:0]                       res_req,
	input logic [`MMUL_LANES-1:0]                       res_gnt,
	input mmul_data_pkg::res_wr_t [`MMUL_LANES-1:0]     res_wr
);

	int fail_cnt = 0; // failed property count

	gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(opnd_gnt) && $onehot0(res_gnt))
	else begin
		$error("more than one lane granted by an arbiter");
		fail_cnt++;
	end

	done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		done_tick |=> !done_tick)
	else begin
		$error("done_tick longer than one cycle");
		fail_cnt++;
	end

	done_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
		done_tick |-> !busy && $past(busy))
	else begin
		$error("done_tick without busy falling on the same edge");
		fail_cnt++;
	end

	load_idle: assert property (@(posedge clk) disable iff (!arst_n)
		ld_we |-> !busy)
	else begin
		$error("operand load while busy");
		fail_cnt++;
	end

	for (genvar g = 0; g < `MMUL_LANES; g++) begin : g_hold
		opnd_hold: assert property (@(posedge clk) disable iff (!arst_n)
			opnd_req[g] && !opnd_gnt[g] |=> opnd_req[g] && $stable(opnd_addr[g]))
		else begin
			$error("lane %0d dropped or changed a waiting operand request", g);
			fail_cnt++;
		end

		res_hold: assert property (@(posedge clk) disable iff (!arst_n)
			res_req[g] && !res_gnt[g] |=> res_req[g] && $stable(res_wr[g]))
		else begin
			$error("lane %0d dropped or changed a waiting result write", g);
			fail_cnt++;
		end

		// refused lane wins within the rotation
		opnd_wait: assert property (@(posedge clk) disable iff (!arst_n)
			opnd_req[g] && !opnd_gnt[g] |-> ##[1:`MMUL_LANES-1] opnd_gnt[g])
		else begin
			$error("lane %0d waited too long for an operand grant", g);
			fail_cnt++;
		end

		res_wait: assert property (@(posedge clk) disable iff (!arst_n)
			res_req[g] && !res_gnt[g] |-> ##[1:`MMUL_LANES-1] res_gnt[g])
		else begin
			$error("lane %0d waited too long for a result grant", g);
			fail_cnt++;
		end
	end

endmodule

bind mmul_top mmul_props props_i (.*);

/* testbench/mmul_tb.sv */
`timescale 1ns/10ps

`include "mmul_params.svh"

module mmul_tb;

	localparam int DIM        = `MMUL_DIM;
	localparam int MAX_CYCLES = 4000; // 4 x (72 load + ~550 run + 36 read) plus margin

	logic                      clk;
	logic                      arst_n;
	logic                      ld_we;
	mmul_ctrl_pkg::opnd_addr_t ld_addr;
	mmul_data_pkg::elem_t      ld_data;
	logic                      start;
	logic                      busy;
	logic                      done_tick;
	mmul_ctrl_pkg::res_addr_t  rd_addr;
	mmul_data_pkg::acc_t       rd_data;

	int     a_m   [DIM][DIM];
	int     b_m   [DIM][DIM];
	longint exp_m [DIM][DIM];
	int     cycle_cnt;
	int     both_req_cnt;

	mmul_top mmul_top_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.ld_we     (ld_we),
		.ld_addr   (ld_addr),
		.ld_data   (ld_data),
		.start     (start),
		.busy      (busy),
		.done_tick (done_tick),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (&mmul_top_i.opnd_req) begin
			both_req_cnt++; // lanes contending
		end
		if (mmul_top_i.props_i.fail_cnt != 0) begin
			$display("[ERROR] a bound property of mmul_top failed");
			$display("Result: FAILED");
			$fatal(1, "property failure");
		end else if (cycle_cnt >= MAX_CYCLES) begin
			$display("[ERROR] timeout, no finish within %0d cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input longint expected, input longint actual);
		assert (actual == expected) else begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	function automatic int rand_elem();
		logic [15:0] r;
		r = 16'($urandom);
		return int'($signed(r));
	endfunction

	function automatic void fill_identity();
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				a_m[r][c]   = (r == c) ? 1 : 0;
				b_m[r][c]   = ((r * DIM + c) * 1871) % 65536 - 32768;
				exp_m[r][c] = b_m[r][c]; // I x B = B
			end
		end
	endfunction

	function automatic void fill_random(input bit extremes);
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				a_m[r][c] = rand_elem();
				b_m[r][c] = rand_elem();
			end
		end
		if (extremes) begin
			for (int n = 0; n < DIM; n++) begin
				a_m[0][n]     = -32768; // largest positive sum at C(0,0)
				b_m[n][0]     = -32768;
				a_m[DIM-1][n] = 32767;
				b_m[n][DIM-1] = 32767;
			end
		end
	endfunction

	function automatic void compute_model();
		longint sum;
		for (int i = 0; i < DIM; i++) begin
			for (int j = 0; j < DIM; j++) begin
				sum = 0;
				for (int k = 0; k < DIM; k++) begin
					sum += longint'(a_m[i][k]) * longint'(b_m[k][j]);
				end
				exp_m[i][j] = sum;
			end
		end
	endfunction

	task automatic write_operand(input int addr, input int value);
		ld_we   = 1'b1;
		ld_addr = mmul_ctrl_pkg::opnd_addr_t'(addr);
		ld_data = mmul_data_pkg::elem_t'(value);
		next_cycle();
	endtask

	// column-major, A at c*6+r and B at 36+c*6+r
	task automatic load_operands();
		for (int c = 0; c < DIM; c++) begin
			for (int r = 0; r < DIM; r++) begin
				write_operand(c * DIM + r, a_m[r][c]);
				write_operand(DIM * DIM + c * DIM + r, b_m[r][c]);
			end
		end
		ld_we = 1'b0;
	endtask

	task automatic run_to_done(input string name, input bit pulse_busy);
		int cyc;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		check_value({name, " busy after start"}, 1, busy);
		cyc = 0;
		while (!done_tick) begin
			start = pulse_busy && busy && (cyc % 64 == 3); // must be ignored
			next_cycle();
			cyc++;
		end
		start = 1'b0;
		check_value({name, " busy at done_tick"}, 0, busy);
	endtask

	task automatic expect_quiet(input string name, input int n);
		int extra;
		extra = 0;
		repeat (n) begin
			next_cycle();
			if (done_tick) begin
				extra++;
			end
		end
		check_value({name, " extra done_tick"}, 0, extra);
		check_value({name, " busy"}, 0, busy);
	endtask

	task automatic check_results(input string name);
		for (int e = 0; e < DIM * DIM; e++) begin
			rd_addr = mmul_ctrl_pkg::res_addr_t'(e);
			next_cycle();
			check_value($sformatf("%s C(%0d,%0d)", name, e % DIM, e / DIM),
				exp_m[e % DIM][e / DIM], longint'(rd_data));
		end
	endtask

	initial begin
		void'($urandom(32'h2d2b_7e35));
		arst_n  = 1'b0;
		ld_we   = 1'b0;
		ld_addr = '0;
		ld_data = '0;
		start   = 1'b0;
		rd_addr = '0;
		repeat (5) @(posedge clk);
		#2;
		arst_n = 1'b1;
		repeat (3) begin
			next_cycle();
			check_value("reset busy", 0, busy);
			check_value("reset done_tick", 0, done_tick);
			check_value("reset grants", 0, {mmul_top_i.opnd_gnt, mmul_top_i.res_gnt});
		end

		fill_identity();
		load_operands();
		run_to_done("identity", 1'b0);
		check_results("identity");

		fill_random(1'b1);
		compute_model();
		load_operands();
		run_to_done("random_extremes", 1'b1);
		expect_quiet("start_while_busy", 20);
		check_results("random_extremes");

		fill_random(1'b0);
		load_operands();
		compute_model();
		run_to_done("back_to_back", 1'b0);
		fill_random(1'b0); // next operands go in before the readback
		load_operands();
		check_results("back_to_back");
		compute_model();
		run_to_done("second_run", 1'b1);
		check_results("second_run");

		assert (both_req_cnt > 0) else begin
			$display("[ERROR] contention: the lanes never requested operands together");
			$display("Result: FAILED");
			$fatal(1, "no contention");
		end
		if (mmul_top_i.props_i.fail_cnt == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("[ERROR] %0d bound property failures", mmul_top_i.props_i.fail_cnt);
			$display("Result: FAILED");
			$fatal(1, "property failures");
		end
	end

endmodule

/* build.f */
+incdir+verilog
verilog/mmul_ctrl_pkg.sv
verilog/mmul_data_pkg.sv
verilog/matrix_store.sv
verilog/rr_arbiter.sv
verilog/dot_product_lane.sv
verilog/mmul_sequencer.sv
verilog/mmul_top.sv
testbench/mmul_props.sv
testbench/mmul_tb.sv

/* Bender.yml */
package:
  name: mmul

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mmul_ctrl_pkg.sv
      - verilog/mmul_data_pkg.sv
      - verilog/matrix_store.sv
      - verilog/rr_arbiter.sv
      - verilog/dot_product_lane.sv
      - verilog/mmul_sequencer.sv
      - verilog/mmul_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/mmul_props.sv
      - testbench/mmul_tb.sv
